// ==== design/branch_defs.svh ====
// RV32I only with no compressed extension; widths are fixed and not meant to be overridden
`ifndef BRANCH_DEFS_SVH
`define BRANCH_DEFS_SVH

`define BR_XLEN         32          // Data and address width
`define BR_RD_W         5           // Register index width

`define BR_OPC_BRANCH   7'b1100011  // Conditional branch opcode
`define BR_OPC_JAL      7'b1101111  // Jump and link
`define BR_OPC_JALR     7'b1100111  // Jump and link register

`define BR_F3_BEQ       3'b000
`define BR_F3_BNE       3'b001
`define BR_F3_BLT       3'b100      // Signed compares
`define BR_F3_BGE       3'b101
`define BR_F3_BLTU      3'b110      // Unsigned compares
`define BR_F3_BGEU      3'b111
`define BR_F3_JALR      3'b000      // Only legal funct3 for JALR

`endif

// ==== design/branch_pkg.sv ====
// Packed stage payloads; field widths follow branch_defs.svh and the op encoding is 4 bits
`include "branch_defs.svh"

package branch_pkg;

    // Operation decoded from opcode and funct3
    typedef enum logic [3:0] {
        BR_BEQ  = 4'd0,
        BR_BNE  = 4'd1,
        BR_BLT  = 4'd2,
        BR_BGE  = 4'd3,
        BR_BLTU = 4'd4,
        BR_BGEU = 4'd5,
        BR_JAL  = 4'd6,             // Unconditional, pc relative
        BR_JALR = 4'd7,             // Unconditional, register relative
        BR_NONE = 4'd8              // Not a control transfer
    } br_op_t;

    // Decode to branch unit
    typedef struct packed {
        br_op_t              op;
        logic [`BR_XLEN-1:0] pc;
        logic [`BR_XLEN-1:0] opa;    // rs1, or pc for JAL
        logic [`BR_XLEN-1:0] opb;    // rs2, or immediate for jumps
        logic [`BR_XLEN-1:0] offset; // Immediate of the instruction, zero for NONE
        logic [`BR_RD_W-1:0] rd;     // Zero unless JAL or JALR
    } dec_pkt_t;

    // Branch unit to redirect stage
    typedef struct packed {
        logic                taken;
        logic [`BR_XLEN-1:0] target;
        logic [`BR_XLEN-1:0] link;   // pc + 4
        logic                link_we;
        logic [`BR_RD_W-1:0] rd;
    } res_pkt_t;

endpackage

// ==== design/pipe_stage.sv ====
// One-entry valid/ready slot; payload is not reset and is only meaningful while out_valid is high
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;                              // Slot occupied
    payload_t data_q;                               // Held item

    // Accept when empty or when the held item leaves this cycle
    assign in_ready  = !valid_q || out_ready;
    assign out_valid = valid_q;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;                        // Empty after reset
        end else if (in_ready) begin
            valid_q <= in_valid;                    // Refill or drain
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;                      // Load only on transfer
        end
    end

endmodule

// ==== design/branch_decode.sv ====
// RV32I decode of BRANCH, JAL and JALR only; JALR needs funct3 000, anything else becomes NONE
`include "branch_defs.svh"

module branch_decode
    import branch_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [`BR_XLEN-1:0] in_pc,
    input  logic [`BR_XLEN-1:0] in_instr,
    input  logic [`BR_XLEN-1:0] in_rs1,
    input  logic [`BR_XLEN-1:0] in_rs2,
    output logic                dec_valid,
    input  logic                dec_ready,
    output dec_pkt_t            dec_pkt
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [`BR_RD_W-1:0] rd_idx;
    logic [`BR_XLEN-1:0] imm_b;                     // Branch offset
    logic [`BR_XLEN-1:0] imm_j;                     // JAL offset
    logic [`BR_XLEN-1:0] imm_i;                     // JALR offset
    br_op_t              op;
    dec_pkt_t            dec_nxt;                   // Packet before the stage register

    assign opcode = in_instr[6:0];
    assign funct3 = in_instr[14:12];
    assign rd_idx = in_instr[11:7];

    // Immediates, all sign extended from bit 31
    assign imm_b = {{19{in_instr[31]}}, in_instr[31], in_instr[7],
                    in_instr[30:25], in_instr[11:8], 1'b0};
    assign imm_j = {{11{in_instr[31]}}, in_instr[31], in_instr[19:12],
                    in_instr[20], in_instr[30:21], 1'b0};
    assign imm_i = {{20{in_instr[31]}}, in_instr[31:20]};

    always_comb begin
        op = BR_NONE;                               // Default for anything unrecognised
        case (opcode)
            `BR_OPC_BRANCH: begin
                case (funct3)
                    `BR_F3_BEQ:  op = BR_BEQ;
                    `BR_F3_BNE:  op = BR_BNE;
                    `BR_F3_BLT:  op = BR_BLT;
                    `BR_F3_BGE:  op = BR_BGE;
                    `BR_F3_BLTU: op = BR_BLTU;
                    `BR_F3_BGEU: op = BR_BGEU;
                    default:     op = BR_NONE;      // 010 and 011 are reserved
                endcase
            end
            `BR_OPC_JAL:  op = BR_JAL;
            `BR_OPC_JALR: op = (funct3 == `BR_F3_JALR) ? BR_JALR : BR_NONE;
            default:      op = BR_NONE;             // ALU, loads, stores and the rest
        endcase
    end

    // Operand routing per operation
    always_comb begin
        dec_nxt.op     = op;
        dec_nxt.pc     = in_pc;
        dec_nxt.opa    = in_rs1;
        dec_nxt.opb    = in_rs2;
        dec_nxt.offset = '0;
        dec_nxt.rd     = '0;                        // Only jumps write a register
        case (op)
            BR_JAL: begin
                dec_nxt.opa    = in_pc;             // Target is pc + imm_j
                dec_nxt.opb    = imm_j;
                dec_nxt.offset = imm_j;
                dec_nxt.rd     = rd_idx;
            end
            BR_JALR: begin
                dec_nxt.opb    = imm_i;             // Target is rs1 + imm_i
                dec_nxt.offset = imm_i;
                dec_nxt.rd     = rd_idx;
            end
            BR_NONE: begin
                dec_nxt.offset = '0;                // Target falls back to pc
            end
            default: begin
                dec_nxt.offset = imm_b;             // Conditional branches compare rs1, rs2
            end
        endcase
    end

    pipe_stage #(
        .payload_t (dec_pkt_t)
    ) dec_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (dec_nxt),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out_data  (dec_pkt)
    );

endmodule

// ==== design/branch_unit.sv ====
// Resolves condition and target from a decoded packet; NONE gives target pc and never writes
`include "branch_defs.svh"

module branch_unit
    import branch_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     dec_valid,
    output logic     dec_ready,
    input  dec_pkt_t dec_pkt,
    output logic     res_valid,
    input  logic     res_ready,
    output res_pkt_t res_pkt
);

    logic [`BR_XLEN-1:0] sum_ab;                    // Jump target before alignment
    logic [`BR_XLEN-1:0] target;
    logic                taken;
    logic                is_jump;
    res_pkt_t            res_nxt;

    assign sum_ab  = dec_pkt.opa + dec_pkt.opb;
    assign is_jump = (dec_pkt.op == BR_JAL) || (dec_pkt.op == BR_JALR);

    always_comb begin
        case (dec_pkt.op)
            BR_JAL:  target = sum_ab;
            BR_JALR: target = {sum_ab[`BR_XLEN-1:1], 1'b0};     // Spec clears bit 0
            default: target = dec_pkt.pc + dec_pkt.offset;      // Branches, and pc for NONE
        endcase
    end

    // Condition per op
    always_comb begin
        case (dec_pkt.op)
            BR_BEQ:  taken = (dec_pkt.opa == dec_pkt.opb);
            BR_BNE:  taken = (dec_pkt.opa != dec_pkt.opb);
            BR_BLT:  taken = ($signed(dec_pkt.opa) < $signed(dec_pkt.opb));
            BR_BGE:  taken = ($signed(dec_pkt.opa) >= $signed(dec_pkt.opb));
            BR_BLTU: taken = (dec_pkt.opa < dec_pkt.opb);
            BR_BGEU: taken = (dec_pkt.opa >= dec_pkt.opb);
            BR_JAL,
            BR_JALR: taken = 1'b1;                  // Always redirect
            default: taken = 1'b0;                  // NONE
        endcase
    end

    always_comb begin
        res_nxt.taken   = taken;
        res_nxt.target  = target;
        res_nxt.link    = dec_pkt.pc + `BR_XLEN'd4; // Return address
        res_nxt.link_we = is_jump && (dec_pkt.rd != '0);  // x0 is never written
        res_nxt.rd      = dec_pkt.rd;
    end

    pipe_stage #(
        .payload_t (res_pkt_t)
    ) res_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .in_data   (res_nxt),
        .out_valid (res_valid),
        .out_ready (res_ready),
        .out_data  (res_pkt)
    );

endmodule

// ==== design/redirect_gen.sv ====
// Output stage; misalignment means target[1:0] nonzero on a taken item, as there is no RVC
`include "branch_defs.svh"

module redirect_gen
    import branch_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                res_valid,
    output logic                res_ready,
    input  res_pkt_t            res_pkt,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                out_redirect,
    output logic [`BR_XLEN-1:0] out_target,
    output logic                out_misaligned,
    output logic                out_link_we,
    output logic [`BR_RD_W-1:0] out_rd,
    output logic [`BR_XLEN-1:0] out_link
);

    logic misaligned;                               // Taken to a non word address
    logic load;                                     // Transfer from the branch unit

    assign misaligned = res_pkt.taken && (res_pkt.target[1:0] != 2'b00);
    assign res_ready  = !out_valid || out_ready;
    assign load       = res_valid && res_ready;

    // Valid and the control flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid      <= 1'b0;
            out_redirect   <= 1'b0;
            out_misaligned <= 1'b0;
            out_link_we    <= 1'b0;
        end else begin
            if (res_ready) begin
                out_valid <= res_valid;             // Hold while stalled
            end
            if (load) begin
                out_redirect   <= res_pkt.taken && !misaligned;
                out_misaligned <= misaligned;
                out_link_we    <= res_pkt.link_we && !misaligned;   // No write on a fault
            end
        end
    end

    // Payload fields pass through as computed
    always_ff @(posedge clk) begin
        if (load) begin
            out_target <= res_pkt.target;
            out_rd     <= res_pkt.rd;
            out_link   <= res_pkt.link;
        end
    end

endmodule

// ==== design/branch_resolve_top.sv ====
// Three-stage decode, resolve, redirect chain; latency 3 cycles, one item per cycle without stalls
`include "branch_defs.svh"

module branch_resolve_top
    import branch_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [`BR_XLEN-1:0] in_pc,
    input  logic [`BR_XLEN-1:0] in_instr,
    input  logic [`BR_XLEN-1:0] in_rs1,
    input  logic [`BR_XLEN-1:0] in_rs2,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                out_redirect,
    output logic [`BR_XLEN-1:0] out_target,
    output logic                out_misaligned,
    output logic                out_link_we,
    output logic [`BR_RD_W-1:0] out_rd,
    output logic [`BR_XLEN-1:0] out_link
);

    logic     dec_valid;                            // Decode to unit
    logic     dec_ready;
    dec_pkt_t dec_pkt;
    logic     res_valid;                            // Unit to redirect
    logic     res_ready;
    res_pkt_t res_pkt;

    branch_decode decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pc     (in_pc),
        .in_instr  (in_instr),
        .in_rs1    (in_rs1),
        .in_rs2    (in_rs2),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_pkt   (dec_pkt)
    );

    branch_unit unit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_pkt   (dec_pkt),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_pkt   (res_pkt)
    );

    redirect_gen redirect_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .res_valid      (res_valid),
        .res_ready      (res_ready),
        .res_pkt        (res_pkt),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_redirect   (out_redirect),
        .out_target     (out_target),
        .out_misaligned (out_misaligned),
        .out_link_we    (out_link_we),
        .out_rd         (out_rd),
        .out_link       (out_link)
    );

endmodule

// ==== tests/branch_resolve_checker.sv ====
// Protocol rules for branch_resolve_top; stall checks are off while rst_n is low
`include "branch_defs.svh"

module branch_resolve_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                in_valid,
    input logic                in_ready,
    input logic [`BR_XLEN-1:0] in_pc,
    input logic [`BR_XLEN-1:0] in_instr,
    input logic [`BR_XLEN-1:0] in_rs1,
    input logic [`BR_XLEN-1:0] in_rs2,
    input logic                out_valid,
    input logic                out_ready,
    input logic                out_redirect,
    input logic [`BR_XLEN-1:0] out_target,
    input logic                out_misaligned,
    input logic                out_link_we,
    input logic [`BR_RD_W-1:0] out_rd,
    input logic [`BR_XLEN-1:0] out_link
);

    int unsigned err_cnt = 0;                       // Number of failed assertions

    in_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_pc) && $stable(in_instr)
                                  && $stable(in_rs1) && $stable(in_rs2))
        else begin
            err_cnt++;
            $error("Input item changed while stalled");
        end

    out_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_redirect)
            && $stable(out_target) && $stable(out_misaligned) && $stable(out_link_we)
            && $stable(out_rd) && $stable(out_link))
        else begin
            err_cnt++;
            $error("Output item changed while stalled");
        end

    reset_a: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            err_cnt++;
            $error("out_valid high during reset");
        end

    excl_a: assert property (@(posedge clk) !(out_redirect && out_misaligned))
        else begin
            err_cnt++;
            $error("Redirect raised on a misaligned target");
        end

endmodule

bind branch_resolve_top branch_resolve_checker checker_i (.*);

// ==== tests/branch_resolve_tb.sv ====
// Random RV32I control-flow items through the DUT; needs the checker bound to the top as checker_i
`include "branch_defs.svh"

module branch_resolve_tb;

    localparam int NUM_ITEMS = 400;
    localparam int BURST     = 20;                  // Leading items sent back to back
    localparam int TIMEOUT   = NUM_ITEMS * 4 + 200; // Cycle budget for the whole run
    localparam logic [2:0] F3_LIST [0:5] = '{`BR_F3_BEQ, `BR_F3_BNE, `BR_F3_BLT,
                                             `BR_F3_BGE, `BR_F3_BLTU, `BR_F3_BGEU};

    // Expected response of one item
    typedef struct packed {
        logic                redirect;
        logic [`BR_XLEN-1:0] target;
        logic                misaligned;
        logic                link_we;
        logic [`BR_RD_W-1:0] rd;
        logic [`BR_XLEN-1:0] link;
    } exp_t;

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    logic                in_ready;
    logic [`BR_XLEN-1:0] in_pc;
    logic [`BR_XLEN-1:0] in_instr;
    logic [`BR_XLEN-1:0] in_rs1;
    logic [`BR_XLEN-1:0] in_rs2;
    logic                out_valid;
    logic                out_ready;
    logic                out_redirect;
    logic [`BR_XLEN-1:0] out_target;
    logic                out_misaligned;
    logic                out_link_we;
    logic [`BR_RD_W-1:0] out_rd;
    logic [`BR_XLEN-1:0] out_link;

    logic [31:0] lfsr;                              // Random state
    exp_t        exp_q[$];                          // Items in flight, oldest first
    logic        in_fire  = 1'b0;                   // Input transfer on the coming edge
    int          edge_cnt = 0;
    int          sent     = 0;
    int          acc_cnt  = 0;
    int          out_cnt  = 0;
    int          first_acc_edge = 0;
    int          first_out_edge = 0;

    branch_resolve_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                     // Period 40
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[31]};             // One step per bit
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Expected output from the RV32I branch and jump rules
    function automatic exp_t resolve_ref(input logic [31:0] pc, input logic [31:0] instr,
                                         input logic [31:0] rs1, input logic [31:0] rs2);
        exp_t        e;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] imm_i;
        logic        taken;
        logic        jump;
        opc   = instr[6:0];
        f3    = instr[14:12];
        imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        imm_i = {{20{instr[31]}}, instr[31:20]};
        taken = 1'b0;
        jump  = 1'b0;
        e.target = pc;                              // Non-control items keep pc
        e.rd     = '0;
        e.link   = pc + 32'd4;
        if (opc == `BR_OPC_BRANCH && f3 != 3'b010 && f3 != 3'b011) begin
            e.target = pc + imm_b;
            case (f3)
                `BR_F3_BEQ:  taken = (rs1 == rs2);
                `BR_F3_BNE:  taken = (rs1 != rs2);
                `BR_F3_BLT:  taken = ($signed(rs1) < $signed(rs2));
                `BR_F3_BGE:  taken = !($signed(rs1) < $signed(rs2));
                `BR_F3_BLTU: taken = (rs1 < rs2);
                default:     taken = !(rs1 < rs2); // BGEU
            endcase
        end else if (opc == `BR_OPC_JAL) begin
            jump     = 1'b1;
            e.target = pc + imm_j;
        end else if (opc == `BR_OPC_JALR && f3 == 3'b000) begin
            jump     = 1'b1;
            e.target = (rs1 + imm_i) & ~32'd1;      // Low bit dropped
        end
        if (jump) begin
            taken = 1'b1;
            e.rd  = instr[11:7];
        end
        e.misaligned = taken && (e.target[1:0] != 2'b00);
        e.redirect   = taken && !e.misaligned;
        e.link_we    = jump && (e.rd != '0) && !e.misaligned;
        return e;
    endfunction

    task automatic fail_run();
        $display("Verification failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            fail_run();
        end
    endtask

    // One random item on the input port
    task automatic make_item();
        logic [3:0]  cls;
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        cls   = rand_bits(4);
        instr = rand_bits(32);                      // Random immediate bits
        pc    = rand_bits(30) << 2;                 // Word aligned
        rs1   = rand_bits(32);
        rs2   = rand_bits(32);
        if (cls >= 4'd10) cls = cls - 4'd10;        // Extra weight on branches
        if (rand_bits(2) == 0) instr[11:7] = '0;    // x0 destination
        if (cls < 4'd6) begin
            instr[14:12] = F3_LIST[cls];
            instr[6:0]   = `BR_OPC_BRANCH;
        end else if (cls == 4'd6) begin
            instr[14:13] = 2'b01;                   // Reserved 010 or 011
            instr[6:0]   = `BR_OPC_BRANCH;
        end else if (cls == 4'd7) begin
            instr[6:0] = `BR_OPC_JAL;
        end else if (cls == 4'd8) begin
            instr[14:12] = `BR_F3_JALR;
            instr[6:0]   = `BR_OPC_JALR;
        end else begin
            instr[6:0] = instr[20] ? 7'b0110011 : 7'b0010011;   // ALU reg or imm
        end
        if (rand_bits(3) == 0) rs1[31] = 1'b1;      // Negative rs1
        if (rand_bits(3) == 0) rs2[31] = ~rs1[31];  // Mixed signs
        if (rand_bits(2) == 0) rs2 = rs1;           // Equal operands
        in_pc    <= pc;
        in_instr <= instr;
        in_rs1   <= rs1;
        in_rs2   <= rs2;
    endtask

    initial begin : stimulus
        lfsr      = 32'h663a_e00e;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_pc     = '0;
        in_instr  = '0;
        in_rs1    = '0;
        in_rs2    = '0;
        out_ready = 1'b1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        while (sent < NUM_ITEMS) begin
            @(posedge clk);
            if (in_fire) sent = sent + 1;
            out_ready <= (sent < BURST) ? 1'b1 : (rand_bits(2) != 0);
            if (!in_valid || in_fire) begin
                if (sent < NUM_ITEMS && (sent < BURST || rand_bits(2) != 0)) begin
                    make_item();
                    in_valid <= 1'b1;
                end else begin
                    in_valid <= 1'b0;               // Gap or done
                end
            end
        end
        while (out_cnt < NUM_ITEMS) begin
            @(posedge clk);
            out_ready <= (rand_bits(2) != 0);       // Drain under back-pressure
        end
        out_ready <= 1'b1;
        repeat (10) @(posedge clk);                 // Catch stray outputs
        if (exp_q.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Run ended with %0d expected items never seen", exp_q.size());
            fail_run();
        end
    end

    // Scoreboard at the falling edge, where all ports are settled
    always @(negedge clk) begin : scoreboard
        exp_t e;
        in_fire = rst_n && in_valid && in_ready;
        if (rst_n) begin
            assert (dut_i.checker_i.err_cnt == 0) else begin
                $display("A protocol assertion in the checker failed");
                fail_run();
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() != 0) else begin
                    $display("An unexpected output appeared with no item in flight");
                    fail_run();
                end
                e = exp_q.pop_front();
                check_field("out_redirect", out_redirect, e.redirect);
                check_field("out_target", out_target, e.target);
                check_field("out_misaligned", out_misaligned, e.misaligned);
                check_field("out_link_we", out_link_we, e.link_we);
                check_field("out_rd", out_rd, e.rd);
                check_field("out_link", out_link, e.link);
                if (out_cnt == 0) begin
                    first_out_edge = edge_cnt + 1;  // Edge that takes the first output
                    assert (first_out_edge == first_acc_edge + 3) else begin
                        $display("First output came %0d cycles after the first accept, not 3",
                                 first_out_edge - first_acc_edge);
                        fail_run();
                    end
                end
                if (out_cnt == 15) begin
                    assert (edge_cnt + 1 == first_out_edge + 15) else begin
                        $display("Outputs of the first burst were not one per cycle");
                        fail_run();
                    end
                end
                out_cnt = out_cnt + 1;
            end
            if (in_fire) begin
                if (acc_cnt == 0) first_acc_edge = edge_cnt + 1;
                if (acc_cnt == BURST - 1) begin
                    assert (edge_cnt + 1 == first_acc_edge + BURST - 1) else begin
                        $display("Back-to-back inputs were not accepted one per cycle");
                        fail_run();
                    end
                end
                exp_q.push_back(resolve_ref(in_pc, in_instr, in_rs1, in_rs2));
                acc_cnt = acc_cnt + 1;
            end
        end
    end

    initial begin : watchdog
        forever begin
            @(posedge clk);
            edge_cnt = edge_cnt + 1;
            if (edge_cnt > TIMEOUT) begin
                $display("Timeout after %0d cycles with %0d of %0d outputs seen",
                         edge_cnt, out_cnt, NUM_ITEMS);
                fail_run();
            end
        end
    end

endmodule

// ==== verilog.f ====
+incdir+design
design/branch_pkg.sv
design/pipe_stage.sv
design/branch_decode.sv
design/branch_unit.sv
design/redirect_gen.sv
design/branch_resolve_top.sv
tests/branch_resolve_checker.sv
tests/branch_resolve_tb.sv
